// ==== Makefile ====
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lpbk3 -f compile.f -o tb_lpbk3
	./obj_dir/tb_lpbk3 | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
lpbk3_pkg.sv
seed_ram.sv
line_tracker.sv
req_issuer.sv
rd_checker.sv
lpbk3_top.sv
tb_lpbk3_props.sv
tb_lpbk3.sv

// ==== line_tracker.sv ====
//********************
// per-line ownership fsms, one outstanding request per line
// gives read and write eligibility back to the request walkers
//********************
`timescale 1ns/1ps

module line_tracker (
    input  logic                              Clk_16UI,
    input  logic                              rst,
    input  logic                              wr_issued,       // write transfer this cycle
    input  logic [lpbk3_pkg::LINE_IDX_W-1:0]  wr_issued_line,
    input  logic                              rd_issued,       // read transfer this cycle
    input  logic [lpbk3_pkg::LINE_IDX_W-1:0]  rd_issued_line,
    input  logic                              rd_rsp_valid,
    input  logic [lpbk3_pkg::ADDR_W-1:0]      rd_rsp_addr,
    input  logic                              wr_rsp_valid,
    input  logic [lpbk3_pkg::ADDR_W-1:0]      wr_rsp_addr,
    output logic [lpbk3_pkg::MAX_LINES-1:0]   rd_eligible,     // line in send-read
    output logic [lpbk3_pkg::MAX_LINES-1:0]   wr_eligible      // line in send-write
);

    logic [lpbk3_pkg::LINE_IDX_W-1:0] rd_rsp_line;
    logic [lpbk3_pkg::LINE_IDX_W-1:0] wr_rsp_line;
    logic [lpbk3_pkg::MAX_LINES-1:0]  sent;                    // per line transfer strobe
    logic [lpbk3_pkg::MAX_LINES-1:0]  cmp;                     // per line response strobe

    assign rd_rsp_line = rd_rsp_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W];
    assign wr_rsp_line = wr_rsp_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W];

    // decode channel events to one-hot line strobes
    always_comb
    begin
        sent = '0;
        cmp  = '0;
        if (wr_issued)
            sent[wr_issued_line] = 1'b1;
        if (rd_issued)
            sent[rd_issued_line] = 1'b1;
        if (rd_rsp_valid)
            cmp[rd_rsp_line] = 1'b1;
        if (wr_rsp_valid)
            cmp[wr_rsp_line] = 1'b1;
    end

    //********************
    // one fsm per line
    //********************
    for (genvar n = 0; n < lpbk3_pkg::MAX_LINES; n++)
    begin : g_line
        logic                                owner_fpga;        // odd index, fpga owned
        logic [lpbk3_pkg::LINE_STATE_W-1:0]  state;

        assign owner_fpga     = (n % 2) == 1;
        assign rd_eligible[n] = state == lpbk3_pkg::ST_SEND_RD;
        assign wr_eligible[n] = state == lpbk3_pkg::ST_SEND_WR;

        always_ff @(posedge Clk_16UI)
        begin
            if (rst)
                state <= owner_fpga ? lpbk3_pkg::ST_SEND_WR : lpbk3_pkg::ST_SEND_RD;
            else
            begin
                case (state)
                    lpbk3_pkg::ST_SEND_WR:
                        if (sent[n]) state <= lpbk3_pkg::ST_WR_PEND;
                    lpbk3_pkg::ST_SEND_RD:
                        if (sent[n]) state <= lpbk3_pkg::ST_RD_PEND;
                    lpbk3_pkg::ST_RD_PEND:                          // fpga lines alternate
                        if (cmp[n])
                            state <= owner_fpga ? lpbk3_pkg::ST_SEND_WR
                                                : lpbk3_pkg::ST_SEND_RD;
                    default:                                        // write pending
                        if (cmp[n]) state <= lpbk3_pkg::ST_SEND_RD;
                endcase
            end
        end
    end

endmodule

// ==== lpbk3_pkg.sv ====
//********************
// shared widths, line limit, error codes and per-line state encoding
// for the cache coherency loopback exerciser, referenced by scoped names
//********************
package lpbk3_pkg;

    // address and line geometry
    localparam int ADDR_W     = 20;                 // request/response address width
    localparam int LINE_BIT   = 10;                 // addr bit of line index bit 0
    localparam int LINE_IDX_W = 4;                  // line index width
    localparam int MAX_LINES  = 16;                 // lines walked, one fsm each

    // cache line payload
    localparam int WORD_W = 32;                     // one data word
    localparam int LINE_W = 4 * WORD_W;             // four words per line

    // seed lfsr
    localparam int              SEED_W    = 8;      // seed byte
    localparam logic [SEED_W-1:0] SEED_INIT = 8'h01; // value after reset

    //********************
    // error codes
    //********************
    localparam int                    ERR_CODE_W    = 3;
    localparam logic [ERR_CODE_W-1:0] ERR_NONE      = 3'd0; // no error seen
    localparam logic [ERR_CODE_W-1:0] ERR_CPU_DATA  = 3'd1; // even line word mismatch
    localparam logic [ERR_CODE_W-1:0] ERR_FPGA_DATA = 3'd2; // odd line word mismatch
    localparam logic [ERR_CODE_W-1:0] ERR_LINE_CNT  = 3'd3; // num_lines below 2

    //********************
    // per-line state
    //********************
    localparam int                      LINE_STATE_W = 2;
    localparam logic [LINE_STATE_W-1:0] ST_RD_PEND   = 2'd0; // read out, awaiting rsp
    localparam logic [LINE_STATE_W-1:0] ST_WR_PEND   = 2'd1; // write out, awaiting rsp
    localparam logic [LINE_STATE_W-1:0] ST_SEND_RD   = 2'd2; // may issue a read
    localparam logic [LINE_STATE_W-1:0] ST_SEND_WR   = 2'd3; // may issue a write

endpackage

// ==== lpbk3_tests.txt ====
# name num_lines dst_addr(hex) corrupt_line(99 none) corrupt_word expected_err_code
# err codes 0 none, 1 cpu data, 2 fpga data, 3 line count
clean_8 8 00a50000 99 0 0
clean_2 2 c0de0000 99 0 0
cpu_line2_w0 8 12345000 2 0 1
cpu_line4_w2 8 5a5a0000 4 2 1
cpu_line0_w0 8 0000f000 0 0 1
fpga_line3_w1 8 abcd0000 3 1 2
fpga_line5_w3 8 76540000 5 3 2
fpga_line1_w0 8 0f0f0000 1 0 2
line_cnt_1 1 11110000 99 0 3

// ==== lpbk3_top.sv ====
//********************
// loopback exerciser top, connects tracker, issuer, seed ram and checker
//********************
`timescale 1ns/1ps

module lpbk3_top (
    input  logic                              Clk_16UI,
    input  logic                              rst,
    input  logic                              go,
    input  logic [lpbk3_pkg::LINE_IDX_W:0]    num_lines,
    input  logic [lpbk3_pkg::WORD_W-1:0]      dst_addr,
    input  logic                              wr_ready,
    input  logic                              rd_ready,
    input  logic                              rd_rsp_valid,
    input  logic [lpbk3_pkg::ADDR_W-1:0]      rd_rsp_addr,
    input  logic [lpbk3_pkg::LINE_W-1:0]      rd_rsp_data,
    input  logic                              wr_rsp_valid,
    input  logic [lpbk3_pkg::ADDR_W-1:0]      wr_rsp_addr,
    output logic                              wr_valid,
    output logic [lpbk3_pkg::ADDR_W-1:0]      wr_addr,
    output logic [lpbk3_pkg::LINE_W-1:0]      wr_data,
    output logic                              rd_valid,
    output logic [lpbk3_pkg::ADDR_W-1:0]      rd_addr,
    output logic                              err_valid,
    output logic [lpbk3_pkg::ERR_CODE_W-1:0]  err_code,
    output logic [lpbk3_pkg::ADDR_W-1:0]      err_addr,
    output logic [lpbk3_pkg::WORD_W-1:0]      err_expected,
    output logic [lpbk3_pkg::WORD_W-1:0]      err_received
);

    logic [lpbk3_pkg::MAX_LINES-1:0]  rd_eligible;
    logic [lpbk3_pkg::MAX_LINES-1:0]  wr_eligible;
    logic                             wr_issued;
    logic [lpbk3_pkg::LINE_IDX_W-1:0] wr_issued_line;
    logic                             rd_issued;
    logic [lpbk3_pkg::LINE_IDX_W-1:0] rd_issued_line;
    logic                             seed_we;
    logic [lpbk3_pkg::LINE_IDX_W-1:0] seed_waddr;
    logic [lpbk3_pkg::SEED_W-1:0]     seed_wdata;
    logic [lpbk3_pkg::LINE_IDX_W-1:0] seed_raddr;
    logic [lpbk3_pkg::SEED_W-1:0]     seed_rdata;

    line_tracker u_tracker (                                    // responses go straight in
        .Clk_16UI, .rst,
        .wr_issued, .wr_issued_line, .rd_issued, .rd_issued_line,
        .rd_rsp_valid, .rd_rsp_addr, .wr_rsp_valid, .wr_rsp_addr,
        .rd_eligible, .wr_eligible
    );

    req_issuer u_issuer (
        .Clk_16UI, .rst, .go, .num_lines, .dst_addr,
        .wr_ready, .rd_ready, .rd_eligible, .wr_eligible,
        .wr_valid, .wr_addr, .wr_data, .rd_valid, .rd_addr,
        .wr_issued, .wr_issued_line, .rd_issued, .rd_issued_line,
        .seed_we, .seed_waddr, .seed_wdata
    );

    seed_ram u_seed_ram (
        .Clk_16UI,
        .we    (seed_we),
        .waddr (seed_waddr),
        .wdata (seed_wdata),
        .raddr (seed_raddr),
        .rdata (seed_rdata)
    );

    rd_checker u_checker (
        .Clk_16UI, .rst, .go, .num_lines, .dst_addr,
        .rd_rsp_valid, .rd_rsp_addr, .rd_rsp_data,
        .seed_rdata, .seed_raddr,
        .err_valid, .err_code, .err_addr, .err_expected, .err_received
    );

endmodule

// ==== rd_checker.sv ====
//********************
// read response checker, registers the response against the seed ram read
// first mismatch or bad line count sets a sticky error until reset
//********************
`timescale 1ns/1ps

module rd_checker (
    input  logic                                Clk_16UI,
    input  logic                                rst,
    input  logic                                go,
    input  logic [lpbk3_pkg::LINE_IDX_W:0]      num_lines,
    input  logic [lpbk3_pkg::WORD_W-1:0]        dst_addr,
    input  logic                                rd_rsp_valid,
    input  logic [lpbk3_pkg::ADDR_W-1:0]        rd_rsp_addr,
    input  logic [lpbk3_pkg::LINE_W-1:0]        rd_rsp_data,
    input  logic [lpbk3_pkg::SEED_W-1:0]        seed_rdata,
    output logic [lpbk3_pkg::LINE_IDX_W-1:0]    seed_raddr,
    output logic                                err_valid,
    output logic [lpbk3_pkg::ERR_CODE_W-1:0]    err_code,
    output logic [lpbk3_pkg::ADDR_W-1:0]        err_addr,
    output logic [lpbk3_pkg::WORD_W-1:0]        err_expected,
    output logic [lpbk3_pkg::WORD_W-1:0]        err_received
);

    logic                              rsp_valid_q;
    logic [lpbk3_pkg::ADDR_W-1:0]      rsp_addr_q;
    logic [lpbk3_pkg::LINE_W-1:0]      rsp_data_q;
    logic [lpbk3_pkg::WORD_W-1:0]      exp_addr_q;             // dst xor line addr
    logic [lpbk3_pkg::WORD_W-1:0]      rsp_addr_word;
    logic [lpbk3_pkg::WORD_W-1:0]      w [4];                  // received words
    logic [lpbk3_pkg::WORD_W-1:0]      seed_word;
    logic                              hit;                    // mismatch this cycle
    logic [lpbk3_pkg::WORD_W-1:0]      hit_exp;
    logic [lpbk3_pkg::WORD_W-1:0]      hit_rcv;

    assign seed_raddr = rd_rsp_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W];
    assign seed_word  = {4{seed_rdata}};                        // ram data lines up with _q

    always_comb
    begin
        rsp_addr_word = '0;
        rsp_addr_word[lpbk3_pkg::ADDR_W-1:0] = rd_rsp_addr;
        for (int k = 0; k < 4; k++)
            w[k] = rsp_data_q[k*lpbk3_pkg::WORD_W +: lpbk3_pkg::WORD_W];
    end

    // fixed check order, first failing word wins
    always_comb
    begin
        hit     = 1'b1;
        hit_exp = exp_addr_q;
        hit_rcv = w[0];
        if (rsp_addr_q[lpbk3_pkg::LINE_BIT] && w[1] != seed_word)
        begin
            hit_exp = seed_word;
            hit_rcv = w[1];
        end
        else if (rsp_addr_q[lpbk3_pkg::LINE_BIT] && w[3] != ~seed_word)
        begin
            hit_exp = ~seed_word;
            hit_rcv = w[3];
        end
        else if (w[0] != exp_addr_q)
            hit_rcv = w[0];                                     // both owners
        else if (w[2] != exp_addr_q)
            hit_rcv = w[2];
        else
            hit = 1'b0;
    end

    //********************
    // response stage and sticky error
    //********************
    always_ff @(posedge Clk_16UI)
    begin
        rsp_addr_q <= rd_rsp_addr;
        rsp_data_q <= rd_rsp_data;
        exp_addr_q <= dst_addr ^ rsp_addr_word;
        if (rst)
        begin
            rsp_valid_q <= 1'b0;
            err_valid   <= 1'b0;
            err_code    <= lpbk3_pkg::ERR_NONE;
        end
        else
        begin
            rsp_valid_q <= rd_rsp_valid;
            if (!err_valid)                                     // stop after first error
            begin
                if (go && num_lines <= (lpbk3_pkg::LINE_IDX_W+1)'(1))
                begin
                    err_valid    <= 1'b1;
                    err_code     <= lpbk3_pkg::ERR_LINE_CNT;
                    err_addr     <= '0;
                    err_expected <= '0;
                    err_received <= '0;
                end
                else if (rsp_valid_q && hit)
                begin
                    err_valid    <= 1'b1;
                    err_code     <= rsp_addr_q[lpbk3_pkg::LINE_BIT] ? lpbk3_pkg::ERR_FPGA_DATA
                                                                    : lpbk3_pkg::ERR_CPU_DATA;
                    err_addr     <= rsp_addr_q;
                    err_expected <= hit_exp;
                    err_received <= hit_rcv;
                end
            end
        end
    end

endmodule

// ==== req_issuer.sv ====
//********************
// read and write request walkers with valid/ready handshake
// forms address and line data, runs the seed lfsr, records written seeds
//********************
`timescale 1ns/1ps

module req_issuer (
    input  logic                              Clk_16UI,
    input  logic                              rst,
    input  logic                              go,
    input  logic [lpbk3_pkg::LINE_IDX_W:0]    num_lines,
    input  logic [lpbk3_pkg::WORD_W-1:0]      dst_addr,
    input  logic                              wr_ready,
    input  logic                              rd_ready,
    input  logic [lpbk3_pkg::MAX_LINES-1:0]   rd_eligible,
    input  logic [lpbk3_pkg::MAX_LINES-1:0]   wr_eligible,
    output logic                              wr_valid,
    output logic [lpbk3_pkg::ADDR_W-1:0]      wr_addr,
    output logic [lpbk3_pkg::LINE_W-1:0]      wr_data,
    output logic                              rd_valid,
    output logic [lpbk3_pkg::ADDR_W-1:0]      rd_addr,
    output logic                              wr_issued,
    output logic [lpbk3_pkg::LINE_IDX_W-1:0]  wr_issued_line,
    output logic                              rd_issued,
    output logic [lpbk3_pkg::LINE_IDX_W-1:0]  rd_issued_line,
    output logic                              seed_we,
    output logic [lpbk3_pkg::LINE_IDX_W-1:0]  seed_waddr,
    output logic [lpbk3_pkg::SEED_W-1:0]      seed_wdata
);

    logic [lpbk3_pkg::LINE_IDX_W-1:0] wr_idx;                  // odd indices only
    logic [lpbk3_pkg::LINE_IDX_W-1:0] rd_idx;                  // every index
    logic [lpbk3_pkg::LINE_IDX_W:0]   wr_nxt;
    logic [lpbk3_pkg::LINE_IDX_W:0]   rd_nxt;
    logic                             wr_can;                  // idle walker may raise valid
    logic                             rd_can;
    logic [lpbk3_pkg::SEED_W-1:0]     seed;
    logic [lpbk3_pkg::WORD_W-1:0]     wr_line_addr;            // line addr as a word
    logic [lpbk3_pkg::WORD_W-1:0]     rd_line_addr;
    logic [lpbk3_pkg::WORD_W-1:0]     addr_word;               // dst xor addr pattern

    always_comb
    begin
        wr_line_addr = '0;
        rd_line_addr = '0;
        wr_line_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W] = wr_idx;
        rd_line_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W] = rd_idx;
    end

    assign addr_word = dst_addr ^ wr_line_addr;
    assign wr_addr   = wr_line_addr[lpbk3_pkg::ADDR_W-1:0];    // idx stable while valid
    assign rd_addr   = rd_line_addr[lpbk3_pkg::ADDR_W-1:0];

    // index wrap at num_lines
    assign rd_nxt = ({1'b0, rd_idx} + 1'b1 >= num_lines) ? '0 : {1'b0, rd_idx} + 1'b1;
    assign wr_nxt = ({1'b0, wr_idx} + 2'd2 >= num_lines) ? 1 : {1'b0, wr_idx} + 2'd2;
    assign rd_can = rd_eligible[rd_idx] && ({1'b0, rd_idx} < num_lines);
    assign wr_can = wr_eligible[wr_idx] && ({1'b0, wr_idx} < num_lines);

    assign wr_issued      = wr_valid && wr_ready;
    assign rd_issued      = rd_valid && rd_ready;
    assign wr_issued_line = wr_idx;
    assign rd_issued_line = rd_idx;
    assign seed_we        = wr_issued;                          // remember seed per line
    assign seed_waddr     = wr_idx;
    assign seed_wdata     = wr_data[lpbk3_pkg::WORD_W +: lpbk3_pkg::SEED_W]; // word 1 byte

    //********************
    // walkers and lfsr
    //********************
    always_ff @(posedge Clk_16UI)
    begin
        if (rst)
        begin
            wr_valid <= 1'b0;
            rd_valid <= 1'b0;
            wr_idx   <= 1;
            rd_idx   <= '0;
            seed     <= lpbk3_pkg::SEED_INIT;
        end
        else
        begin
            seed <= {seed[lpbk3_pkg::SEED_W-2:0], seed[3] ^ seed[4] ^ seed[5] ^ seed[7]};
            if (wr_valid)
            begin
                if (wr_ready)                                   // transfer, drop and step
                begin
                    wr_valid <= 1'b0;
                    wr_idx   <= wr_nxt[lpbk3_pkg::LINE_IDX_W-1:0];
                end
            end
            else if (go)
            begin
                if (wr_can)
                    wr_valid <= 1'b1;
                else
                    wr_idx <= wr_nxt[lpbk3_pkg::LINE_IDX_W-1:0];  // skip busy line
            end
            if (rd_valid)
            begin
                if (rd_ready)
                begin
                    rd_valid <= 1'b0;
                    rd_idx   <= rd_nxt[lpbk3_pkg::LINE_IDX_W-1:0];
                end
            end
            else if (go)
            begin
                if (rd_can)
                    rd_valid <= 1'b1;
                else
                    rd_idx <= rd_nxt[lpbk3_pkg::LINE_IDX_W-1:0];
            end
        end
    end

    // line data captured as valid rises, held through back-pressure
    always_ff @(posedge Clk_16UI)
    begin
        if (!wr_valid && go && wr_can)
            wr_data <= {{4{~seed}}, addr_word, {4{seed}}, addr_word}; // words 3..0
    end

endmodule

// ==== seed_ram.sv ====
//********************
// seed byte store, one entry per line, registered read port
//********************
`timescale 1ns/1ps

module seed_ram (
    input  logic                              Clk_16UI,
    input  logic                              we,       // write on write transfer
    input  logic [lpbk3_pkg::LINE_IDX_W-1:0]  waddr,    // written line index
    input  logic [lpbk3_pkg::SEED_W-1:0]      wdata,    // seed byte of that write
    input  logic [lpbk3_pkg::LINE_IDX_W-1:0]  raddr,    // response line index
    output logic [lpbk3_pkg::SEED_W-1:0]      rdata     // valid one cycle after raddr
);

    logic [lpbk3_pkg::SEED_W-1:0] mem [lpbk3_pkg::MAX_LINES]; // last seed per line

    always_ff @(posedge Clk_16UI)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];                                  // sync read
    end

endmodule

// ==== tb_lpbk3.sv ====
//********************
// testbench for the loopback exerciser, host memory model with random delays
// rows of lpbk3_tests.txt each run after their own reset
//********************
`timescale 1ns/1ps

module tb_lpbk3;

    localparam int MAX_ROWS  = 32;
    localparam int RSP_CLEAN = 60;                      // read responses in a clean row

    logic                                  Clk_16UI;
    logic                                  rst;
    logic                                  go;
    logic [lpbk3_pkg::LINE_IDX_W:0]        num_lines;
    logic [lpbk3_pkg::WORD_W-1:0]          dst_addr;
    logic                                  wr_ready;
    logic                                  rd_ready;
    logic                                  rd_rsp_valid;
    logic [lpbk3_pkg::ADDR_W-1:0]          rd_rsp_addr;
    logic [lpbk3_pkg::LINE_W-1:0]          rd_rsp_data;
    logic                                  wr_rsp_valid;
    logic [lpbk3_pkg::ADDR_W-1:0]          wr_rsp_addr;
    logic                                  wr_valid;
    logic [lpbk3_pkg::ADDR_W-1:0]          wr_addr;
    logic [lpbk3_pkg::LINE_W-1:0]          wr_data;
    logic                                  rd_valid;
    logic [lpbk3_pkg::ADDR_W-1:0]          rd_addr;
    logic                                  err_valid;
    logic [lpbk3_pkg::ERR_CODE_W-1:0]      err_code;
    logic [lpbk3_pkg::ADDR_W-1:0]          err_addr;
    logic [lpbk3_pkg::WORD_W-1:0]          err_expected;
    logic [lpbk3_pkg::WORD_W-1:0]          err_received;

    // rows from the data file
    string       names [MAX_ROWS];
    int          row_lines [MAX_ROWS];
    logic [31:0] row_dst [MAX_ROWS];
    int          row_cline [MAX_ROWS];
    int          row_cword [MAX_ROWS];
    int          row_code [MAX_ROWS];
    int          rows;
    int          errors;
    int          limit;                                 // timeout in cycles
    int          cycles;
    string       cur_name;
    int          cur_cline;
    int          cur_cword;

    // host memory model
    logic [lpbk3_pkg::LINE_W-1:0]  mem [lpbk3_pkg::MAX_LINES];
    logic [lpbk3_pkg::MAX_LINES-1:0] outstanding;       // request out with no rsp yet
    logic [lpbk3_pkg::MAX_LINES-1:0] written;
    logic [lpbk3_pkg::MAX_LINES-1:0] read_seen;
    logic [lpbk3_pkg::ADDR_W-1:0]  rd_q_addr [$];
    logic [lpbk3_pkg::LINE_W-1:0]  rd_q_data [$];
    logic [lpbk3_pkg::ADDR_W-1:0]  wr_q_addr [$];
    int          rd_dly, wr_dly, rdy_rd_cnt, rdy_wr_cnt;
    logic        wr_ready_nxt, rd_ready_nxt;
    logic        corrupt_done;
    int          rsp_count;
    logic [31:0] exp_err_addr, exp_err_exp, exp_err_rcv;

    lpbk3_top uut (.*);

    initial
    begin
        Clk_16UI = 1'b0;
        forever #4 Clk_16UI = ~Clk_16UI;                // 8 ns period
    end

    function automatic logic [31:0] line_addr(input int idx);
        return 32'(idx) << lpbk3_pkg::LINE_BIT;
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act)
        else
        begin
            errors++;
            $display("ERROR %s: %s expected %h actual %h", cur_name, what, exp, act);
        end
    endtask

    task automatic confirm(input logic ok, input string msg);
        assert (ok)
        else
        begin
            errors++;
            $display("%s: %s", cur_name, msg);
        end
    endtask

    //********************
    // host side of both channels
    //********************
    task automatic take_write();
        int          idx;
        logic [31:0] w [4];
        idx = int'(wr_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W]);
        for (int k = 0; k < 4; k++)
            w[k] = wr_data[k*32 +: 32];
        check_value("write word 0", dst_addr ^ line_addr(idx), w[0]);
        check_value("write word 2", dst_addr ^ line_addr(idx), w[2]);
        check_value("write word 1", {4{w[1][7:0]}}, w[1]);
        check_value("write word 3", ~w[1], w[3]);
        confirm(idx % 2 == 1 && idx < int'(num_lines),
                "write to a line that is not an odd line in range");
        confirm(!outstanding[idx], "write to a line whose last request has no response yet");
        mem[idx]         = wr_data;
        written[idx]     = 1'b1;
        outstanding[idx] = 1'b1;
        wr_q_addr.push_back(wr_addr);
    endtask

    task automatic take_read();
        int                           idx;
        logic [lpbk3_pkg::LINE_W-1:0] d;
        idx = int'(rd_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W]);
        confirm(idx < int'(num_lines), "read of a line above the line count");
        confirm(!outstanding[idx], "read of a line whose last request has no response yet");
        confirm(idx % 2 == 0 || written[idx], "read of an odd line before any write to it");
        d = mem[idx];
        if (idx == cur_cline && !corrupt_done)          // first read of the target
        begin
            exp_err_addr = line_addr(idx);
            exp_err_exp  = d[cur_cword*32 +: 32];
            d[cur_cword*32 +: 32] = d[cur_cword*32 +: 32] ^ 32'h8000_0001;
            exp_err_rcv  = d[cur_cword*32 +: 32];
            corrupt_done = 1'b1;
        end
        outstanding[idx] = 1'b1;
        read_seen[idx]   = 1'b1;
        rd_q_addr.push_back(rd_addr);
        rd_q_data.push_back(d);
    endtask

    initial
    begin
        forever
        begin
            @(negedge Clk_16UI);                         // outputs settled here
            wr_ready_nxt = 1'b0;
            rd_ready_nxt = 1'b0;
            if (rst)
            begin
                rd_q_addr.delete();
                rd_q_data.delete();
                wr_q_addr.delete();
                outstanding  = '0;
                written      = '0;
                read_seen    = '0;
                corrupt_done = 1'b0;
                rsp_count    = 0;
                rd_dly       = 0;
                wr_dly       = 0;
                rdy_rd_cnt   = 0;
                rdy_wr_cnt   = 0;
                for (int i = 0; i < lpbk3_pkg::MAX_LINES; i++)
                    mem[i] = {32'h0, dst_addr ^ line_addr(i), 32'h0, dst_addr ^ line_addr(i)};
            end
            else
            begin
                if (wr_valid && wr_ready)
                begin
                    take_write();
                    rdy_wr_cnt = int'($urandom % 4);
                end
                else if (wr_valid)
                begin
                    if (rdy_wr_cnt == 0) wr_ready_nxt = 1'b1;
                    else rdy_wr_cnt--;
                end
                if (rd_valid && rd_ready)
                begin
                    take_read();
                    rdy_rd_cnt = int'($urandom % 4);
                end
                else if (rd_valid)
                begin
                    if (rdy_rd_cnt == 0) rd_ready_nxt = 1'b1;
                    else rdy_rd_cnt--;
                end
            end
            @(posedge Clk_16UI);
            #1;
            wr_ready     = wr_ready_nxt;
            rd_ready     = rd_ready_nxt;
            rd_rsp_valid = 1'b0;
            wr_rsp_valid = 1'b0;
            if (rd_dly > 0)
                rd_dly--;
            else if (rd_q_addr.size() > 0 && !rst)      // one pulse per cycle
            begin
                rd_rsp_valid = 1'b1;
                rd_rsp_addr  = rd_q_addr.pop_front();
                rd_rsp_data  = rd_q_data.pop_front();
                outstanding[rd_rsp_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W]] = 1'b0;
                rsp_count++;
                rd_dly = int'($urandom % 4);
            end
            if (wr_dly > 0)
                wr_dly--;
            else if (wr_q_addr.size() > 0 && !rst)
            begin
                wr_rsp_valid = 1'b1;
                wr_rsp_addr  = wr_q_addr.pop_front();
                outstanding[wr_rsp_addr[lpbk3_pkg::LINE_BIT +: lpbk3_pkg::LINE_IDX_W]] = 1'b0;
                wr_dly = int'($urandom % 4);
            end
        end
    end

    // run limit
    initial
    begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge Clk_16UI);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", limit);
        $display("Test failed");
        $finish;
    end

    //********************
    // row sequence
    //********************
    task automatic run_row(input int r);
        @(posedge Clk_16UI);
        #1;
        go        = 1'b0;
        rst       = 1'b1;
        cur_name  = names[r];
        cur_cline = row_cline[r];
        cur_cword = row_cword[r];
        num_lines = (lpbk3_pkg::LINE_IDX_W+1)'(row_lines[r]);
        dst_addr  = row_dst[r];
        repeat (4) @(posedge Clk_16UI);
        #1;
        rst = 1'b0;
        @(posedge Clk_16UI);
        #1;
        go = 1'b1;
        if (row_code[r] == int'(lpbk3_pkg::ERR_NONE))
        begin
            while (rsp_count < RSP_CLEAN)
                @(posedge Clk_16UI);
            repeat (2) @(posedge Clk_16UI);             // last response reaches err_valid
            #1;
            check_value("err_valid", 32'h0, 32'(err_valid));
            for (int i = 0; i < row_lines[r]; i++)
                confirm(read_seen[i], $sformatf("line %0d was never read", i));
        end
        else
        begin
            while (!err_valid)
                @(posedge Clk_16UI);
            #1;
            check_value("err_code", 32'(row_code[r]), 32'(err_code));
            if (row_code[r] != int'(lpbk3_pkg::ERR_LINE_CNT))
            begin
                check_value("err_addr", exp_err_addr, 32'(err_addr));
                check_value("err_expected", exp_err_exp, err_expected);
                check_value("err_received", exp_err_rcv, err_received);
            end
            else
            begin
                check_value("err_addr", 32'h0, 32'(err_addr));  // line count has zero words
                check_value("err_expected", 32'h0, err_expected);
                check_value("err_received", 32'h0, err_received);
            end
        end
        go = 1'b0;
    endtask

    initial
    begin
        int    fd;
        int    n;
        string text;
        string nm;
        int    lines_v, cline_v, cword_v, code_v;
        logic [31:0] dst_v;
        rst          = 1'b1;
        go           = 1'b0;
        num_lines    = '0;
        dst_addr     = '0;
        wr_ready     = 1'b0;
        rd_ready     = 1'b0;
        rd_rsp_valid = 1'b0;
        rd_rsp_addr  = '0;
        rd_rsp_data  = '0;
        wr_rsp_valid = 1'b0;
        wr_rsp_addr  = '0;
        errors       = 0;
        rows         = 0;
        limit        = 0;
        void'($urandom(32'hb27a_a380));
        fd = $fopen("lpbk3_tests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the test data file");
            $display("Test failed");
        end
        else
        begin
            while (!$feof(fd) && rows < MAX_ROWS)
            begin
                n = $fgets(text, fd);
                if (n > 0)                               // nothing read at end of file
                    n = $sscanf(text, "%s %d %h %d %d %d",
                                nm, lines_v, dst_v, cline_v, cword_v, code_v);
                if (n == 6 && nm.getc(0) != "#")        // skip comment lines
                begin
                    names[rows]     = nm;
                    row_lines[rows] = lines_v;
                    row_dst[rows]   = dst_v;
                    row_cline[rows] = cline_v;
                    row_cword[rows] = cword_v;
                    row_code[rows]  = code_v;
                    rows++;
                end
            end
            $fclose(fd);
            limit = 400 * (rows > 0 ? rows : 1);
            for (int r = 0; r < rows; r++)
                run_row(r);
            confirm(rows > 0, "no test rows were read");
            $display("rows run: %0d, errors: %0d, assertion failures: %0d",
                     rows, errors, uut.u_props.fails);
            if (errors == 0 && uut.u_props.fails == 0)
                $display("Test passed");
            else
                $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== tb_lpbk3_props.sv ====
//********************
// handshake properties on the request channels, bound into the top level
//********************
`timescale 1ns/1ps

module lpbk3_props (
    input logic                              Clk_16UI,
    input logic                              rst,
    input logic                              wr_valid,
    input logic                              wr_ready,
    input logic [lpbk3_pkg::ADDR_W-1:0]      wr_addr,
    input logic [lpbk3_pkg::LINE_W-1:0]      wr_data,
    input logic                              rd_valid,
    input logic                              rd_ready,
    input logic [lpbk3_pkg::ADDR_W-1:0]      rd_addr
);

    int fails = 0;                                   // assertion failure count

    // request held until accepted
    wr_hold: assert property (@(posedge Clk_16UI) disable iff (rst)
        wr_valid && !wr_ready |=> wr_valid && $stable(wr_addr) && $stable(wr_data))
        else
        begin
            fails++;
            $error("write request changed before it was accepted");
        end

    rd_hold: assert property (@(posedge Clk_16UI) disable iff (rst)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_addr))
        else
        begin
            fails++;
            $error("read request changed before it was accepted");
        end

    idle_in_rst: assert property (@(posedge Clk_16UI) rst |=> !wr_valid && !rd_valid)
        else
        begin
            fails++;
            $error("request valid high during reset");
        end

    wr_odd: assert property (@(posedge Clk_16UI) disable iff (rst)
        wr_valid |-> wr_addr[lpbk3_pkg::LINE_BIT])
        else
        begin
            fails++;
            $error("write request to an even line");
        end

endmodule

bind lpbk3_top lpbk3_props u_props (.*);
